//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+source
source/uart_line_pkg.sv
source/uart_host_pkg.sv
source/baud_tick_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_ctrl.sv
source/uart_top.sv
testbench/tb_clock_gen.sv
testbench/uart_tb.sv

//--- source/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module baud_tick_gen (
   input  logic clk,
   input  logic reset,
   output logic tick
);

   localparam int CNT_W = $clog2(`UART_CLK_PER_TICK);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLK_PER_TICK - 1);

   logic [CNT_W-1:0] count;

   // free-running divider, tick registered at wrap
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= '0;
         tick  <= 1'b0;
      end
      else if (count == CNT_LAST)
      begin
         count <= '0;
         tick  <= 1'b1;
      end
      else
      begin
         count <= count + 1'b1;
         tick  <= 1'b0;
      end
   end

   // tick must be a single-cycle strobe
   assert property (@(posedge clk) disable iff (reset) tick |=> !tick);

endmodule

`default_nettype wire

//--- source/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// clk cycles per oversampling tick, kept small for simulation
`define UART_CLK_PER_TICK 4

// oversampling ticks in one bit period
`define UART_TICKS_PER_BIT 16

// data bits in one 8N1 frame
`define UART_DATA_BITS 8

`endif

//--- source/uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl
   import uart_line_pkg::*, uart_host_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  send_req_t    send,
   input  logic         clear_overrun,
   input  logic         tx_done,
   input  logic         tx_active,
   input  logic         rx_done,
   input  uart_byte_t   rx_data,
   input  logic         rx_frame_error,
   output logic         tx_go,
   output uart_byte_t   tx_data,
   output recv_report_t recv,
   output logic         overrun,
   output logic         tx_busy
);

   uart_byte_t held_data;
   logic       held_full;
   logic       engine_busy;
   logic       drain;
   logic       start_now;
   logic       hold_now;
   logic       drop_now;

   // a pending tx_go counts as busy since the frame starts next cycle
   assign engine_busy = tx_active | tx_go;
   // frame ending with a byte waiting
   assign drain       = tx_done & held_full;
   // transmitter takes a new byte when idle or on its last stop tick
   assign start_now   = send.valid & ~held_full & (~engine_busy | tx_done);
   // register frees up in the same cycle it drains
   assign hold_now    = send.valid & ~start_now & engine_busy & (~held_full | drain);
   assign drop_now    = send.valid & ~start_now & ~hold_now;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_go      <= 1'b0;
         held_full  <= 1'b0;
         overrun    <= 1'b0;
         recv.valid <= 1'b0;
      end
      else
      begin
         tx_go      <= start_now | drain;
         held_full  <= hold_now | (held_full & ~drain);
         // sticky flag where a new drop wins over clear
         overrun    <= drop_now | (overrun & ~clear_overrun);
         recv.valid <= rx_done;
      end
   end

   // byte payloads
   always_ff @(posedge clk)
   begin
      if (drain)
         tx_data <= held_data;
      else if (start_now)
         tx_data <= send.data;
      if (hold_now)
         held_data <= send.data;
      if (rx_done)
      begin
         recv.data          <= rx_data;
         recv.framing_error <= rx_frame_error;
      end
   end

   assign tx_busy = tx_active | held_full | tx_go;

   // transmitter only gets a start while idle
   assert property (@(posedge clk) disable iff (reset) $rose(tx_go) |-> !tx_active);

endmodule

`default_nettype wire

//--- source/uart_host_pkg.sv
`default_nettype none

package uart_host_pkg;

   import uart_line_pkg::*;

   // host send strobe with its byte
   // valid is high for one cycle per byte
   typedef struct packed {
      logic       valid;
      uart_byte_t data;
   } send_req_t;

   // report of one received frame
   // framing_error set when the stop sample was low
   typedef struct packed {
      logic       valid;
      uart_byte_t data;
      logic       framing_error;
   } recv_report_t;

endpackage

`default_nettype wire

//--- source/uart_line_pkg.sv
`default_nettype none

`include "uart_config.svh"

package uart_line_pkg;

   // one data byte as seen on the serial line
   typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

   // tick position inside one bit period
   typedef logic [$clog2(`UART_TICKS_PER_BIT)-1:0] tick_count_t;

   // data bit position inside the frame
   typedef logic [$clog2(`UART_DATA_BITS)-1:0] bit_index_t;

   // transmitter states
   typedef enum logic [1:0] {
      tx_st_idle,
      tx_st_start,
      tx_st_data,
      tx_st_stop
   } tx_state_t;

   // receiver states
   typedef enum logic [1:0] {
      rx_st_idle,
      rx_st_start,
      rx_st_data,
      rx_st_stop
   } rx_state_t;

endpackage

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_rx
   import uart_line_pkg::*;
#(
   parameter int DATA_BITS = `UART_DATA_BITS
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       tick,
   input  logic       rx,
   output logic       rx_done,
   output uart_byte_t rx_data,
   output logic       rx_frame_error
);

   localparam tick_count_t HALF_LAST = tick_count_t'(`UART_TICKS_PER_BIT / 2 - 1);
   localparam tick_count_t BIT_LAST  = tick_count_t'(`UART_TICKS_PER_BIT - 1);

   logic        rx_meta;
   logic        rx_sync;
   rx_state_t   state;
   tick_count_t tick_cnt;
   bit_index_t  bit_idx;
   logic        stop_end;

   // two-flop synchronizer, preset high so reset never looks like a start bit
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   // stop bit centre reached
   assign stop_end = (state == rx_st_stop) && tick && (tick_cnt == BIT_LAST);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= rx_st_idle;
         tick_cnt <= '0;
         bit_idx  <= '0;
         rx_done  <= 1'b0;
      end
      else
      begin
         rx_done <= stop_end;
         case (state)
            rx_st_idle:
            begin
               // falling edge starts the half-bit wait
               if (!rx_sync)
               begin
                  state    <= rx_st_start;
                  tick_cnt <= '0;
               end
            end
            rx_st_start:
            begin
               if (tick)
               begin
                  if (tick_cnt == HALF_LAST)
                  begin
                     // still low at mid start bit, otherwise a glitch
                     state    <= rx_sync ? rx_st_idle : rx_st_data;
                     tick_cnt <= '0;
                     bit_idx  <= '0;
                  end
                  else
                     tick_cnt <= tick_cnt + 1'b1;
               end
            end
            rx_st_data:
            begin
               if (tick)
               begin
                  if (tick_cnt == BIT_LAST)
                  begin
                     tick_cnt <= '0;
                     if (bit_idx == bit_index_t'(DATA_BITS - 1))
                        state <= rx_st_stop;
                     else
                        bit_idx <= bit_idx + 1'b1;
                  end
                  else
                     tick_cnt <= tick_cnt + 1'b1;
               end
            end
            rx_st_stop:
            begin
               if (tick)
               begin
                  if (tick_cnt == BIT_LAST)
                     state <= rx_st_idle;
                  else
                     tick_cnt <= tick_cnt + 1'b1;
               end
            end
            default:
               state <= rx_st_idle;
         endcase
      end
   end

   // data shifted in LSB first at each bit centre
   always_ff @(posedge clk)
   begin
      if ((state == rx_st_data) && tick && (tick_cnt == BIT_LAST))
         rx_data <= {rx_sync, rx_data[$bits(uart_byte_t)-1:1]};
      if (stop_end)
         rx_frame_error <= !rx_sync;
   end

endmodule

`default_nettype wire

//--- source/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top
   import uart_line_pkg::*, uart_host_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  send_req_t    send,
   input  logic         clear_overrun,
   output recv_report_t recv,
   output logic         overrun,
   output logic         tx_busy,
   output logic         tx,
   input  logic         rx
);

   logic       tick;
   logic       tx_go;
   uart_byte_t tx_data;
   logic       tx_done;
   logic       tx_active;
   logic       rx_done;
   uart_byte_t rx_data;
   logic       rx_frame_error;

   // host side control
   uart_ctrl u_ctrl (
      .clk            (clk),
      .reset          (reset),
      .send           (send),
      .clear_overrun  (clear_overrun),
      .tx_done        (tx_done),
      .tx_active      (tx_active),
      .rx_done        (rx_done),
      .rx_data        (rx_data),
      .rx_frame_error (rx_frame_error),
      .tx_go          (tx_go),
      .tx_data        (tx_data),
      .recv           (recv),
      .overrun        (overrun),
      .tx_busy        (tx_busy)
   );

   // shared oversampling tick
   baud_tick_gen u_tick (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   uart_tx u_tx (
      .clk       (clk),
      .reset     (reset),
      .tick      (tick),
      .tx_go     (tx_go),
      .tx_data   (tx_data),
      .tx_done   (tx_done),
      .tx_active (tx_active),
      .tx        (tx)
   );

   uart_rx u_rx (
      .clk            (clk),
      .reset          (reset),
      .tick           (tick),
      .rx             (rx),
      .rx_done        (rx_done),
      .rx_data        (rx_data),
      .rx_frame_error (rx_frame_error)
   );

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx
   import uart_line_pkg::*;
#(
   parameter int DATA_BITS = `UART_DATA_BITS
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       tick,
   input  logic       tx_go,
   input  uart_byte_t tx_data,
   output logic       tx_done,
   output logic       tx_active,
   output logic       tx
);

   localparam tick_count_t BIT_LAST = tick_count_t'(`UART_TICKS_PER_BIT - 1);

   tx_state_t   state, state_next;
   tick_count_t tick_cnt, tick_next;
   bit_index_t  bit_idx, bit_next;
   uart_byte_t  shift, shift_next;
   logic        tx_next;

   // control state and line register
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= tx_st_idle;
         tick_cnt <= '0;
         bit_idx  <= '0;
         tx       <= 1'b1;
      end
      else
      begin
         state    <= state_next;
         tick_cnt <= tick_next;
         bit_idx  <= bit_next;
         tx       <= tx_next;
      end
   end

   // data shifter
   always_ff @(posedge clk)
   begin
      shift <= shift_next;
   end

   // line value is set on each transition so tx follows the state directly
   always_comb
   begin
      state_next = state;
      tick_next  = tick_cnt;
      bit_next   = bit_idx;
      shift_next = shift;
      tx_next    = tx;
      tx_done    = 1'b0;
      case (state)
         tx_st_idle:
         begin
            if (tx_go)
            begin
               state_next = tx_st_start;
               tick_next  = '0;
               shift_next = tx_data;
               tx_next    = 1'b0;
            end
         end
         tx_st_start:
         begin
            if (tick)
            begin
               if (tick_cnt == BIT_LAST)
               begin
                  state_next = tx_st_data;
                  tick_next  = '0;
                  bit_next   = '0;
                  tx_next    = shift[0];
               end
               else
                  tick_next = tick_cnt + 1'b1;
            end
         end
         tx_st_data:
         begin
            if (tick)
            begin
               if (tick_cnt == BIT_LAST)
               begin
                  tick_next  = '0;
                  shift_next = shift >> 1;
                  // last data bit done, go to stop bit
                  if (bit_idx == bit_index_t'(DATA_BITS - 1))
                  begin
                     state_next = tx_st_stop;
                     tx_next    = 1'b1;
                  end
                  else
                  begin
                     bit_next = bit_idx + 1'b1;
                     tx_next  = shift[1];
                  end
               end
               else
                  tick_next = tick_cnt + 1'b1;
            end
         end
         tx_st_stop:
         begin
            // full-length stop bit
            if (tick)
            begin
               if (tick_cnt == BIT_LAST)
               begin
                  state_next = tx_st_idle;
                  tx_done    = 1'b1;
               end
               else
                  tick_next = tick_cnt + 1'b1;
            end
         end
         default:
            state_next = tx_st_idle;
      endcase
   end

   assign tx_active = (state != tx_st_idle);

   // line must rest high between frames
   assert property (@(posedge clk) disable iff (reset) (state == tx_st_idle) |-> tx);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic reset
);

   // free-running clock, low first half
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset held over the first rising edges, released on a falling edge
   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- testbench/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tb
   import uart_line_pkg::*, uart_host_pkg::*;
();

   localparam int FRAME_BITS    = `UART_DATA_BITS + 2;
   localparam int BIT_CLKS      = `UART_TICKS_PER_BIT * `UART_CLK_PER_TICK;
   localparam int FRAME_CLKS    = FRAME_BITS * BIT_CLKS;
   localparam int RANDOM_FRAMES = 20;
   // idle check, random frames, held pair, forced frame, glitch wait
   localparam int NUM_FRAMES    = 1 + RANDOM_FRAMES + 2 + 1 + 2;
   localparam int WATCHDOG_CLKS = NUM_FRAMES * FRAME_CLKS * 2 + 1000;

   // line pattern in time order, bit 0 goes out first
   typedef logic [FRAME_BITS-1:0] frame_t;

   logic         clk;
   logic         reset;
   send_req_t    send;
   logic         clear_overrun;
   recv_report_t recv;
   logic         overrun;
   logic         tx_busy;
   logic         tx;
   logic         rx;
   logic         force_mode;
   logic         force_line;

   string        test_name;
   uart_byte_t   tx_expect[$];
   logic [`UART_DATA_BITS:0] rx_expect[$];
   int           rx_sent;
   int           rx_seen;

   tb_clock_gen u_clock (
      .clk   (clk),
      .reset (reset)
   );

   // external loopback or a line driven by the testbench
   assign rx = force_mode ? force_line : tx;

   uart_top UUT (
      .clk           (clk),
      .reset         (reset),
      .send          (send),
      .clear_overrun (clear_overrun),
      .recv          (recv),
      .overrun       (overrun),
      .tx_busy       (tx_busy),
      .tx            (tx),
      .rx            (rx)
   );

   // 8N1 reference with start low, data LSB first and stop high
   function automatic frame_t frame_bits(input uart_byte_t b);
      return {1'b1, b, 1'b0};
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected)
         abort_run($sformatf("ERROR %s: %s expected %0h actual %0h",
                             test_name, what, expected, actual));
   endtask

   // one-cycle send strobe starting on a falling edge
   task automatic send_byte(input uart_byte_t b, input logic accepted);
      send.valid = 1'b1;
      send.data  = b;
      if (accepted)
      begin
         tx_expect.push_back(b);
         rx_expect.push_back({b, 1'b0});
         rx_sent++;
      end
      @(negedge clk);
      send.valid = 1'b0;
   endtask

   // transmitter empty with nothing held
   task automatic wait_idle();
      while (tx_busy)
         @(negedge clk);
   endtask

   task automatic drive_line(input logic v, input int n_clks);
      force_line = v;
      repeat (n_clks) @(negedge clk);
   endtask

   // tx bit centres timed from each falling start edge
   initial
   begin
      logic   tx_prev;
      frame_t fb;
      int     i;
      tx_prev = 1'b1;
      forever
      begin
         @(negedge clk);
         if (!reset && tx_prev && !tx)
         begin
            if (tx_expect.size() == 0)
               abort_run("tx started a frame that no send asked for");
            fb = frame_bits(tx_expect.pop_front());
            // edge seen half a clock late
            repeat (BIT_CLKS / 2 - 1) @(negedge clk);
            compare("tx bit 0", 32'(fb[0]), 32'(tx));
            for (i = 1; i < FRAME_BITS; i++)
            begin
               repeat (BIT_CLKS) @(negedge clk);
               compare($sformatf("tx bit %0d", i), 32'(fb[i]), 32'(tx));
            end
         end
         tx_prev = tx;
      end
   end

   // receive reports checked in order against what was sent
   initial
   begin
      logic [`UART_DATA_BITS:0] exp;
      forever
      begin
         @(negedge clk);
         if (!reset && recv.valid)
         begin
            if (rx_expect.size() == 0)
               abort_run("receive report arrived with no frame on the line");
            exp = rx_expect.pop_front();
            compare("recv data", 32'(exp[`UART_DATA_BITS:1]), 32'(recv.data));
            compare("framing error", 32'(exp[0]), 32'(recv.framing_error));
            rx_seen++;
         end
      end
   end

   // watchdog sized from frame count
   initial
   begin
      repeat (WATCHDOG_CLKS) @(posedge clk);
      abort_run("timeout: the run took longer than the frames allow");
   end

   initial
   begin
      uart_byte_t  b;
      uart_byte_t  b2;
      uart_byte_t  b3;
      frame_t      fb;
      int          i;
      void'($urandom(20582));
      send          = '0;
      clear_overrun = 1'b0;
      force_mode    = 1'b0;
      force_line    = 1'b1;
      rx_sent       = 0;
      rx_seen       = 0;
      test_name     = "reset";
      @(negedge clk);
      while (reset)
         @(negedge clk);

      // quiet line and flags out of reset
      test_name = "idle after reset";
      repeat (FRAME_CLKS)
      begin
         @(negedge clk);
         compare("tx", 32'(1'b1), 32'(tx));
         compare("recv.valid", 32'(1'b0), 32'(recv.valid));
         compare("overrun", 32'(1'b0), 32'(overrun));
         compare("tx_busy", 32'(1'b0), 32'(tx_busy));
      end

      // line format checked by the sampler and data by the report checker
      test_name = "frame format and loopback";
      for (i = 0; i < RANDOM_FRAMES; i++)
      begin
         b = uart_byte_t'($urandom());
         send_byte(b, 1'b1);
         wait_idle();
      end
      // report lands mid stop bit, before the transmitter goes idle
      compare("report count", 32'(rx_sent), 32'(rx_seen));

      test_name = "holding register";
      b  = uart_byte_t'($urandom());
      b2 = uart_byte_t'($urandom());
      b3 = uart_byte_t'($urandom());
      send_byte(b, 1'b1);
      // second byte goes to the holding register
      send_byte(b2, 1'b1);
      compare("overrun after hold", 32'(1'b0), 32'(overrun));
      compare("tx_busy with byte held", 32'(1'b1), 32'(tx_busy));
      // register full so the third byte is dropped
      send_byte(b3, 1'b0);
      compare("overrun after drop", 32'(1'b1), 32'(overrun));
      wait_idle();
      compare("overrun sticky", 32'(1'b1), 32'(overrun));
      clear_overrun = 1'b1;
      @(negedge clk);
      clear_overrun = 1'b0;
      compare("overrun cleared", 32'(1'b0), 32'(overrun));

      test_name = "framing error";
      force_line = 1'b1;
      force_mode = 1'b1;
      @(negedge clk);
      b  = uart_byte_t'($urandom());
      fb = frame_bits(b);
      rx_expect.push_back({b, 1'b1});
      rx_sent++;
      for (i = 0; i < FRAME_BITS - 1; i++)
         drive_line(fb[i], BIT_CLKS);
      // stop held low past its centre
      // released before a new half-bit check
      drive_line(1'b0, BIT_CLKS * 3 / 4);
      drive_line(1'b1, BIT_CLKS);
      compare("report count", 32'(rx_sent), 32'(rx_seen));

      // quarter-bit low pulse is rejected at the start-bit centre
      test_name = "start glitch";
      drive_line(1'b0, BIT_CLKS / 4);
      drive_line(1'b1, FRAME_CLKS * 2);
      force_mode = 1'b0;
      @(negedge clk);

      if (tx_expect.size() != 0 || rx_expect.size() != 0)
         abort_run("frames still outstanding at the end of the run");
      else
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
